// File: design/sdram_fifo_pkg.sv
package sdram_fifo_pkg;

	////////////////////////////////////////////////////////////
	// data words
	////////////////////////////////////////////////////////////

	// one sample word as it arrives from the source
	typedef logic [15:0] word16_t;

	// one ring entry, earlier word of the pair in [15:0]
	typedef logic [31:0] word32_t;

	////////////////////////////////////////////////////////////
	// fill levels
	////////////////////////////////////////////////////////////

	// every fill count in the design uses this width
	typedef logic [15:0] level_t;

	// state report of a FIFO or of the ring
	typedef struct packed {
		level_t count;
		logic   empty;
		logic   full;
	} fifo_level_t;

	////////////////////////////////////////////////////////////
	// default sizes
	////////////////////////////////////////////////////////////

	localparam int DEF_IN_DEPTH   = 32;  // input mini-FIFO, 16-bit words
	localparam int DEF_OUT_DEPTH  = 16;  // output mini-FIFO, 32-bit entries
	localparam int DEF_RING_DEPTH = 64;  // ring buffer, 32-bit entries
	localparam int DEF_BLOCK_SIZE = 8;   // entries needed before out_rdy

endpackage

// File: design/stream_fifo.sv
`timescale 1ns/1ps

module stream_fifo #(
	parameter int  depth     = 16,
	parameter type payload_t = logic [15:0]
) (
	input  logic                       ti_clk,
	input  logic                       reset,
	input  logic                       push,
	input  payload_t                   push_data,
	input  logic                       pop,
	output payload_t                   head,
	output sdram_fifo_pkg::fifo_level_t level
);

	import sdram_fifo_pkg::*;

	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

	// storage has no reset, only pointers and count do
	payload_t           mem [depth];
	logic [ptr_w-1:0]   wr_ptr;
	logic [ptr_w-1:0]   rd_ptr;
	level_t             count;
	logic               do_push;
	logic               do_pop;

	// push to a full FIFO is dropped, pop on empty is ignored
	assign do_push = push && !level.full;
	assign do_pop  = pop && !level.empty;

	////////////////////////////////////////////////////////////
	// pointers and occupancy
	////////////////////////////////////////////////////////////

	always_ff @(posedge ti_clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				// wrap by hand so non power of two depths also work
				wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// push and pop together leave the count alone
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge ti_clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	// first word fall through, head is the oldest entry
	assign head = mem[rd_ptr];

	assign level.count = count;
	assign level.empty = (count == '0);
	assign level.full  = (count == level_t'(depth));

endmodule

// File: design/ring_ram.sv
`timescale 1ns/1ps

module ring_ram #(
	parameter int depth = 64
) (
	input  logic                         ti_clk,
	input  logic                         wr_en,
	input  logic [$clog2(depth)-1:0]     wr_addr,
	input  sdram_fifo_pkg::word32_t      wr_data,
	input  logic                         rd_en,
	input  logic [$clog2(depth)-1:0]     rd_addr,
	output sdram_fifo_pkg::word32_t      rd_data
);

	import sdram_fifo_pkg::*;

	// bulk entry store in place of the external SDRAM
	word32_t mem [depth];

	always_ff @(posedge ti_clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
		// registered read, data shows up one cycle after rd_en
		if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

// File: design/ring_transfer_engine.sv
`timescale 1ns/1ps

module ring_transfer_engine #(
	parameter int ring_depth = 64,
	parameter int out_depth  = 16
) (
	input  logic                            ti_clk,
	input  logic                            reset,
	input  sdram_fifo_pkg::fifo_level_t     in_level,
	input  sdram_fifo_pkg::word16_t         in_head,
	output logic                            in_pop,
	output logic                            wr_en,
	output logic [$clog2(ring_depth)-1:0]   wr_addr,
	output sdram_fifo_pkg::word32_t         wr_data,
	output logic                            rd_en,
	output logic [$clog2(ring_depth)-1:0]   rd_addr,
	input  sdram_fifo_pkg::word32_t         rd_data,
	input  sdram_fifo_pkg::fifo_level_t     out_level,
	output logic                            out_push,
	output sdram_fifo_pkg::word32_t         out_data,
	output sdram_fifo_pkg::fifo_level_t     ring_level
);

	import sdram_fifo_pkg::*;

	localparam int ring_aw = $clog2(ring_depth);

	typedef enum logic {
		pack_idle,
		pack_low_held
	} pack_state_t;

	pack_state_t          pack_state;
	word16_t              low_word;
	logic [ring_aw-1:0]   wr_ptr;
	logic [ring_aw-1:0]   rd_ptr;
	level_t               ring_count;
	logic                 in_flight;
	logic                 pack_start;

	////////////////////////////////////////////////////////////
	// pack path, two input words per ring entry
	////////////////////////////////////////////////////////////

	// only start a pair when both words are already there
	// ring cannot fill up mid pair, the engine is its only writer
	assign pack_start = (pack_state == pack_idle) &&
		(in_level.count >= level_t'(2)) && !ring_level.full;

	always_ff @(posedge ti_clk) begin
		if (reset) begin
			pack_state <= pack_idle;
		end else if (pack_start) begin
			pack_state <= pack_low_held;
		end else if (pack_state == pack_low_held) begin
			pack_state <= pack_idle;
		end
	end

	// low half is payload, no reset
	always_ff @(posedge ti_clk) begin
		if (pack_start) begin
			low_word <= in_head;
		end
	end

	// second pop and the ring write share a cycle
	assign in_pop  = pack_start || (pack_state == pack_low_held);
	assign wr_en   = (pack_state == pack_low_held);
	assign wr_addr = wr_ptr;
	assign wr_data = {in_head, low_word};

	////////////////////////////////////////////////////////////
	// drain path, ring to output FIFO
	////////////////////////////////////////////////////////////

	// ring_count still holds the entry in flight, so skip it here
	// output room counts the entry that is on its way
	assign rd_en = (ring_count > level_t'(in_flight)) &&
		((out_level.count + level_t'(in_flight)) < level_t'(out_depth));
	assign rd_addr = rd_ptr;

	// ram read latency is one cycle, push follows the read
	assign out_push = in_flight;
	assign out_data = rd_data;

	always_ff @(posedge ti_clk) begin
		if (reset) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			ring_count <= '0;
			in_flight  <= 1'b0;
		end else begin
			in_flight <= rd_en;
			if (wr_en) begin
				wr_ptr <= (wr_ptr == ring_aw'(ring_depth - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= (rd_ptr == ring_aw'(ring_depth - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// entry leaves the count when it lands in the output FIFO
			if (wr_en && !out_push) begin
				ring_count <= ring_count + 1'b1;
			end else if (out_push && !wr_en) begin
				ring_count <= ring_count - 1'b1;
			end
		end
	end

	assign ring_level.count = ring_count;
	assign ring_level.empty = (ring_count == '0);
	assign ring_level.full  = (ring_count == level_t'(ring_depth));

endmodule

// File: design/capacity_monitor.sv
`timescale 1ns/1ps

module capacity_monitor #(
	parameter int block_size = 8
) (
	input  logic                         ti_clk,
	input  logic                         reset,
	input  sdram_fifo_pkg::fifo_level_t  in_level,
	input  sdram_fifo_pkg::fifo_level_t  ring_level,
	input  sdram_fifo_pkg::fifo_level_t  out_level,
	output sdram_fifo_pkg::level_t       num_words,
	output logic                         out_rdy
);

	import sdram_fifo_pkg::*;

	level_t ring_words;
	level_t out_words;
	level_t total_words;

	////////////////////////////////////////////////////////////
	// word total, everything in 16-bit words
	////////////////////////////////////////////////////////////

	// ring and output hold packed pairs, so two words per entry
	assign ring_words  = level_t'(ring_level.count << 1);
	assign out_words   = level_t'(out_level.count << 1);
	assign total_words = in_level.count + ring_words + out_words;

	always_ff @(posedge ti_clk) begin
		if (reset) begin
			num_words <= '0;
			out_rdy   <= 1'b0;
		end else begin
			num_words <= total_words;
			// a full block can be read by the host
			out_rdy   <= (out_level.count >= level_t'(block_size));
		end
	end

endmodule

// File: design/sdram_fifo.sv
`timescale 1ns/1ps

module sdram_fifo #(
	parameter int in_depth   = sdram_fifo_pkg::DEF_IN_DEPTH,
	parameter int out_depth  = sdram_fifo_pkg::DEF_OUT_DEPTH,
	parameter int ring_depth = sdram_fifo_pkg::DEF_RING_DEPTH,
	parameter int block_size = sdram_fifo_pkg::DEF_BLOCK_SIZE
) (
	input  logic                    ti_clk,
	input  logic                    reset,
	input  logic                    write_to,
	input  sdram_fifo_pkg::word16_t data_in,
	input  logic                    read_from,
	output sdram_fifo_pkg::word32_t data_out,
	output logic                    out_rdy,
	output sdram_fifo_pkg::level_t  num_words
);

	import sdram_fifo_pkg::*;

	localparam int ring_aw = $clog2(ring_depth);

	fifo_level_t          in_level;
	fifo_level_t          out_level;
	fifo_level_t          ring_level;
	word16_t              in_head;
	logic                 in_pop;
	logic                 wr_en;
	logic [ring_aw-1:0]   wr_addr;
	word32_t              wr_data;
	logic                 rd_en;
	logic [ring_aw-1:0]   rd_addr;
	word32_t              rd_data;
	logic                 out_push;
	word32_t              out_data;

	////////////////////////////////////////////////////////////
	// input mini-FIFO, engine, ring, output mini-FIFO
	////////////////////////////////////////////////////////////

	stream_fifo #(.depth(in_depth), .payload_t(word16_t)) i_in_fifo (
		.ti_clk(ti_clk), .reset(reset), .push(write_to), .push_data(data_in),
		.pop(in_pop), .head(in_head), .level(in_level));

	ring_transfer_engine #(.ring_depth(ring_depth), .out_depth(out_depth)) i_engine (
		.ti_clk(ti_clk), .reset(reset), .in_level(in_level), .in_head(in_head),
		.in_pop(in_pop), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data), .out_level(out_level),
		.out_push(out_push), .out_data(out_data), .ring_level(ring_level));

	ring_ram #(.depth(ring_depth)) i_ring (
		.ti_clk(ti_clk), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data));

	// host reads on empty are ignored, data_out keeps the old head
	stream_fifo #(.depth(out_depth), .payload_t(word32_t)) i_out_fifo (
		.ti_clk(ti_clk), .reset(reset), .push(out_push), .push_data(out_data),
		.pop(read_from), .head(data_out), .level(out_level));

	capacity_monitor #(.block_size(block_size)) i_monitor (
		.ti_clk(ti_clk), .reset(reset), .in_level(in_level), .ring_level(ring_level),
		.out_level(out_level), .num_words(num_words), .out_rdy(out_rdy));

endmodule

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int period       = 20,
	parameter int reset_cycles = 8
) (
	output logic ti_clk,
	output logic reset
);

	// free running clock, period in ns
	initial begin
		ti_clk = 1'b0;
		forever #(period / 2) ti_clk = ~ti_clk;
	end

	// release 1 ns after an edge, same as the other inputs
	initial begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge ti_clk);
		#1;
		reset = 1'b0;
	end

endmodule

// File: sim/sdram_fifo_checker.sv
`timescale 1ns/1ps

module sdram_fifo_checker #(
	parameter int in_depth   = sdram_fifo_pkg::DEF_IN_DEPTH,
	parameter int out_depth  = sdram_fifo_pkg::DEF_OUT_DEPTH,
	parameter int ring_depth = sdram_fifo_pkg::DEF_RING_DEPTH,
	parameter int block_size = sdram_fifo_pkg::DEF_BLOCK_SIZE
) (
	input logic                   ti_clk,
	input logic                   reset,
	input sdram_fifo_pkg::level_t num_words,
	input logic                   out_rdy
);

	import sdram_fifo_pkg::*;

	// storage in 16-bit words, ring and output hold two per entry
	localparam int capacity = in_depth + 2 * ring_depth + 2 * out_depth;

	// failed assertions so far
	int fail_count = 0;

	////////////////////////////////////////////////////////////
	// port level properties
	////////////////////////////////////////////////////////////

	a_within_capacity: assert property (@(posedge ti_clk) disable iff (reset)
		num_words <= level_t'(capacity))
	else begin
		$error("num_words %0d above capacity %0d", num_words, capacity);
		fail_count++;
	end

	// flag is registered, so look one cycle into reset
	a_rdy_low_in_reset: assert property (@(posedge ti_clk)
		(reset && $past(reset)) |-> !out_rdy)
	else begin
		$error("out_rdy high while reset held");
		fail_count++;
	end

	// a full block means at least two words per entry
	a_rdy_needs_block: assert property (@(posedge ti_clk) disable iff (reset)
		$rose(out_rdy) |-> (num_words >= level_t'(2 * block_size)))
	else begin
		$error("out_rdy rose with num_words %0d", num_words);
		fail_count++;
	end

endmodule

// File: sim/sdram_fifo_tb.sv
`timescale 1ns/1ps

module sdram_fifo_tb;

	import sdram_fifo_pkg::*;

	localparam int total_writes = 40 + 7 + 32 + 100 + 121;
	localparam int quiet_cycles = 8;
	localparam int quiet_limit  = 400;
	// unread words kept below capacity during the mixed phase
	localparam int hold_level   = 150;
	// all writes at a slow pace plus every settle wait
	localparam int watchdog_cycles = 20 * total_writes + 10 * quiet_limit;

	logic        ti_clk;
	logic        reset;
	logic        write_to;
	word16_t     data_in;
	logic        read_from;
	word32_t     data_out;
	logic        out_rdy;
	level_t      num_words;
	logic        out_empty;
	logic [31:0] lfsr_state;
	word16_t     ref_words[$];
	int          value_errors;
	int          other_errors;
	int          assert_errors;

	tb_clock_gen #(.period(20), .reset_cycles(8)) i_clock (.ti_clk(ti_clk), .reset(reset));

	sdram_fifo i_dut (
		.ti_clk(ti_clk), .reset(reset), .write_to(write_to), .data_in(data_in),
		.read_from(read_from), .data_out(data_out), .out_rdy(out_rdy),
		.num_words(num_words));

	bind sdram_fifo sdram_fifo_checker #(
		.in_depth(in_depth), .out_depth(out_depth),
		.ring_depth(ring_depth), .block_size(block_size)) i_checker (
		.ti_clk(ti_clk), .reset(reset), .num_words(num_words), .out_rdy(out_rdy));

	// low while data_out holds a real entry
	assign out_empty = i_dut.out_level.empty;

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	// one LFSR step per bit taken
	function automatic logic [31:0] take_bits(input int nbits);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < nbits; i++) begin
			value = {value[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return value;
	endfunction

	// expected entry with the earlier word in the low half
	function automatic word32_t pack_pair(input word16_t first, input word16_t second);
		return {second, first};
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		value_errors++;
		$display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
	endtask

	task automatic write_words(input int n, input bit sparse);
		int      sent;
		word16_t w;
		sent = 0;
		while (sent < n) begin
			@(posedge ti_clk);
			#1;
			if ((sparse && take_bits(1) == 32'd0) || ref_words.size() >= hold_level) begin
				write_to = 1'b0;
			end else begin
				w = word16_t'(take_bits(16));
				data_in  = w;
				write_to = 1'b1;
				ref_words.push_back(w);
				sent++;
			end
		end
		@(posedge ti_clk);
		#1;
		write_to = 1'b0;
	endtask

	// pop only while an entry is present
	// throttle skips every third cycle
	task automatic read_entries(input int n, input bit throttle);
		int done_cnt;
		int cycle_idx;
		done_cnt  = 0;
		cycle_idx = 0;
		while (done_cnt < n) begin
			@(posedge ti_clk);
			#1;
			cycle_idx++;
			if (!out_empty && !(throttle && (cycle_idx % 3 == 2))) begin
				read_from = 1'b1;
				done_cnt++;
			end else begin
				read_from = 1'b0;
			end
			if (cycle_idx > n * 4 + quiet_limit) begin
				other_errors++;
				$display("only %0d of %0d entries became readable", done_cnt, n);
				done_cnt = n;
			end
		end
		@(posedge ti_clk);
		#1;
		read_from = 1'b0;
	endtask

	// settled once num_words holds the expected total for several cycles
	task automatic wait_quiet(input int exp);
		int stable;
		int cycles;
		stable = 0;
		cycles = 0;
		while (stable < quiet_cycles && cycles < quiet_limit) begin
			@(posedge ti_clk);
			#1;
			cycles++;
			if (num_words == level_t'(exp)) begin
				stable++;
			end else begin
				stable = 0;
			end
		end
		if (num_words !== level_t'(exp)) begin
			report_mismatch("num_words", 32'(num_words), 32'(exp));
		end
	endtask

	////////////////////////////////////////////////////////////
	// compare process at mid cycle before each pop
	////////////////////////////////////////////////////////////

	always @(negedge ti_clk) begin : compare_reads
		word16_t first;
		word16_t second;
		if (!reset && read_from && !out_empty) begin
			if (ref_words.size() < 2) begin
				other_errors++;
				$display("an entry was read with no complete pair written");
			end else begin
				first  = ref_words.pop_front();
				second = ref_words.pop_front();
				if (data_out !== pack_pair(first, second)) begin
					report_mismatch("data_out", data_out, pack_pair(first, second));
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////

	initial begin
		write_to     = 1'b0;
		data_in      = '0;
		read_from    = 1'b0;
		lfsr_state   = 32'h1f89_d700;
		value_errors = 0;
		other_errors = 0;
		@(negedge reset);
		@(posedge ti_clk);
		#1;
		// idle after reset
		if (out_rdy !== 1'b0) begin
			report_mismatch("out_rdy", 32'(out_rdy), 32'd0);
		end
		if (num_words !== '0) begin
			report_mismatch("num_words", 32'(num_words), 32'd0);
		end
		// even count comes back as pairs in order
		write_words(40, 1'b0);
		wait_quiet(40);
		read_entries(20, 1'b0);
		wait_quiet(0);
		// odd count leaves the last word waiting for a partner
		write_words(7, 1'b0);
		wait_quiet(7);
		read_entries(3, 1'b0);
		wait_quiet(1);
		if (out_empty !== 1'b1) begin
			other_errors++;
			$display("an entry was formed from a single leftover word");
		end
		// output full and then below one block
		write_words(32, 1'b0);
		wait_quiet(33);
		if (out_rdy !== 1'b1) begin
			report_mismatch("out_rdy", 32'(out_rdy), 32'd1);
		end
		read_entries(9, 1'b0);
		wait_quiet(15);
		if (out_rdy !== 1'b0) begin
			report_mismatch("out_rdy", 32'(out_rdy), 32'd0);
		end
		read_entries(7, 1'b0);
		wait_quiet(1);
		// beyond the output depth the entries wait in the ring
		write_words(100, 1'b0);
		wait_quiet(101);
		read_entries(50, 1'b0);
		wait_quiet(1);
		// mixed traffic
		fork
			write_words(121, 1'b1);
			read_entries(61, 1'b1);
		join
		wait_quiet(0);
		if (out_rdy !== 1'b0) begin
			report_mismatch("out_rdy", 32'(out_rdy), 32'd0);
		end
		if (ref_words.size() != 0) begin
			other_errors++;
			$display("%0d written words were never read back", ref_words.size());
		end
		assert_errors = i_dut.i_checker.fail_count;
		$display("errors: %0d value, %0d other, %0d assertion",
			value_errors, other_errors, assert_errors);
		if (value_errors == 0 && other_errors == 0 && assert_errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		repeat (watchdog_cycles) @(posedge ti_clk);
		$display("run did not finish within %0d cycles", watchdog_cycles);
		$display("errors: %0d value, %0d other, %0d assertion",
			value_errors, other_errors, i_dut.i_checker.fail_count);
		$display("Test failed");
		$finish;
	end

endmodule

// File: sdram_fifo.f
design/sdram_fifo_pkg.sv
design/stream_fifo.sv
design/ring_ram.sv
design/ring_transfer_engine.sv
design/capacity_monitor.sv
design/sdram_fifo.sv
sim/tb_clock_gen.sv
sim/sdram_fifo_checker.sv
sim/sdram_fifo_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the sdram_fifo testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sdram_fifo.f \
	--top-module sdram_fifo_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

# keep running past assertion errors so the testbench can report them
out=$(./obj_dir/Vsdram_fifo_tb +verilator+error+limit+1000)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test completed successfully"; then
	exit 0
fi
exit 1
